//--- x86_isa_pkg.sv
package x86_isa_pkg;

  // Opcodes of the supported instruction subset
  // Codes not listed here execute as a no-operation
  typedef enum logic [6:0] {
    // Arithmetic
    ADD   = 7'h00,
    ADC   = 7'h01,
    INC   = 7'h02,
    SUB   = 7'h03,
    SBB   = 7'h04,
    DEC   = 7'h05,
    CMP   = 7'h06,
    // Logic
    AND   = 7'h08,
    TEST  = 7'h09,
    OR    = 7'h0a,
    XOR   = 7'h0b,
    NOT   = 7'h0c,
    // Shift and rotate
    SHL   = 7'h10,
    SHR   = 7'h11,
    ROL   = 7'h12,
    ROR   = 7'h13,
    // Data movement
    MOV   = 7'h18,
    LEA   = 7'h19,
    MOVSX = 7'h1a,
    MOVZX = 7'h1b,
    XCHG  = 7'h1c,
    // Flag manipulation
    STC   = 7'h20,
    CLC   = 7'h21,
    STD   = 7'h22,
    CLD   = 7'h23,
    LAHF  = 7'h24,
    SAHF  = 7'h25,
    // Control flow
    JMP   = 7'h28,
    JZ    = 7'h29,
    JNZ   = 7'h2a,
    CALLR = 7'h2b,
    CALLI = 7'h2c,
    NOP   = 7'h7f
  } opcode_t;

  // EFLAGS bit positions, architectural layout
  localparam int unsigned EFLAGS_CF = 0;
  localparam int unsigned EFLAGS_PF = 2;
  localparam int unsigned EFLAGS_AF = 4;
  localparam int unsigned EFLAGS_ZF = 6;
  localparam int unsigned EFLAGS_SF = 7;
  localparam int unsigned EFLAGS_TF = 8;
  localparam int unsigned EFLAGS_IF = 9;
  localparam int unsigned EFLAGS_DF = 10;
  localparam int unsigned EFLAGS_OF = 11;

endpackage

//--- exec_ctl_pkg.sv
package exec_ctl_pkg;

  // ALU operations, decoded from the opcode by execute
  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SHL = 4'd5,
    ALU_SHR = 4'd6,
    ALU_ROL = 4'd7,
    ALU_ROR = 4'd8
  } alu_op_t;

  // Compact status vector carried between execute and its units
  // Only the flags the units may touch are in here
  localparam int unsigned STAT_OF = 0;
  localparam int unsigned STAT_SF = 1;
  localparam int unsigned STAT_ZF = 2;
  localparam int unsigned STAT_PF = 3;
  localparam int unsigned STAT_CF = 4;
  localparam int unsigned STAT_AF = 5;
  localparam int unsigned STAT_DF = 6;

  // Move unit kinds
  localparam logic [1:0] MV_COPY = 2'd0;
  // Byte source widened into a full word
  localparam logic [1:0] MV_SEXT = 2'd1;
  localparam logic [1:0] MV_ZEXT = 2'd2;
  // Both operands written back swapped
  localparam logic [1:0] MV_SWAP = 2'd3;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu (
  input  exec_ctl_pkg::alu_op_t op,
  input  logic                  use_carry,
  input  logic                  no_flags,
  input  logic [6:0]            status_in,
  input  logic [31:0]           a,
  input  logic [31:0]           b,
  output logic [31:0]           result,
  output logic [6:0]            status_out
);

  import exec_ctl_pkg::*;

  logic        is_sub;
  logic        carry_in;
  logic [31:0] b_eff;
  logic [32:0] sum;
  logic [31:0] logic_res;
  logic [4:0]  cnt;
  logic [32:0] shl_wide;
  logic [32:0] shr_wide;
  logic [63:0] rol_wide;
  logic [63:0] ror_wide;
  logic        upd_zsp;

  // Subtract goes through the same adder as a + ~b + 1
  // For SBB the incoming borrow takes that 1 away again
  assign is_sub   = (op == ALU_SUB);
  assign b_eff    = is_sub ? ~b : b;
  assign carry_in = is_sub ? ~(use_carry & status_in[STAT_CF])
                           : (use_carry & status_in[STAT_CF]);
  assign sum      = {1'b0, a} + {1'b0, b_eff} + {32'd0, carry_in};

  assign logic_res = (op == ALU_AND) ? (a & b) :
                     (op == ALU_OR)  ? (a | b) :
                                       (a ^ b);

  // Count is the low five bits of b
  assign cnt      = b[4:0];
  // Spare bit on each side catches the last bit shifted out
  assign shl_wide = {1'b0, a} << cnt;
  assign shr_wide = {a, 1'b0} >> cnt;
  // Doubled word turns a rotate into a plain shift
  assign rol_wide = {a, a} << cnt;
  assign ror_wide = {a, a} >> cnt;

  always_comb begin
    result     = a;
    status_out = status_in;
    upd_zsp    = 1'b1;
    case (op)
      ALU_ADD, ALU_SUB: begin
        result              = sum[31:0];
        // Carry out for add, borrow for subtract
        status_out[STAT_CF] = is_sub ? ~sum[32] : sum[32];
        // Overflow when both adder inputs agree in sign and the sum does not
        status_out[STAT_OF] = (a[31] == b_eff[31]) && (sum[31] != a[31]);
        // Carry or borrow into bit 4
        status_out[STAT_AF] = a[4] ^ b[4] ^ sum[4];
      end
      ALU_AND, ALU_OR, ALU_XOR: begin
        result              = logic_res;
        status_out[STAT_CF] = 1'b0;
        status_out[STAT_OF] = 1'b0;
        status_out[STAT_AF] = 1'b0;
      end
      ALU_SHL: begin
        result              = shl_wide[31:0];
        status_out[STAT_OF] = 1'b0;
        // Nothing shifted out on a zero count so CF stays
        if (cnt != 5'd0) begin
          status_out[STAT_CF] = shl_wide[32];
        end
      end
      ALU_SHR: begin
        result              = shr_wide[32:1];
        status_out[STAT_OF] = 1'b0;
        if (cnt != 5'd0) begin
          status_out[STAT_CF] = shr_wide[0];
        end
      end
      ALU_ROL: begin
        result  = rol_wide[63:32];
        upd_zsp = 1'b0;
        // Bit rotated into the LSB
        if (cnt != 5'd0) begin
          status_out[STAT_CF] = rol_wide[32];
        end
      end
      ALU_ROR: begin
        result  = ror_wide[31:0];
        upd_zsp = 1'b0;
        // Bit rotated into the MSB
        if (cnt != 5'd0) begin
          status_out[STAT_CF] = ror_wide[31];
        end
      end
      default: begin
        upd_zsp = 1'b0;
      end
    endcase

    // Result flags, PF is even parity of the low byte
    if (upd_zsp) begin
      status_out[STAT_ZF] = (result == 32'd0);
      status_out[STAT_SF] = result[31];
      status_out[STAT_PF] = ~^result[7:0];
    end

    if (no_flags) begin
      status_out = status_in;
    end
    // The ALU never owns the direction flag
    status_out[STAT_DF] = status_in[STAT_DF];
  end

endmodule

//--- move_unit.sv
`timescale 1ns/1ps

module move_unit (
  input  logic [1:0]  kind,
  input  logic [31:0] opnd0_r,
  input  logic [31:0] opnd1_r,
  output logic [31:0] opnd0_w,
  output logic [31:0] opnd1_w
);

  import exec_ctl_pkg::*;

  always_comb begin
    // Second operand is untouched except on a swap
    opnd1_w = opnd1_r;
    case (kind)
      MV_SEXT: begin
        // MOVSX from a byte source
        opnd0_w = {{24{opnd1_r[7]}}, opnd1_r[7:0]};
      end
      MV_ZEXT: begin
        opnd0_w = {24'd0, opnd1_r[7:0]};
      end
      MV_SWAP: begin
        // XCHG writes both sides
        opnd0_w = opnd1_r;
        opnd1_w = opnd0_r;
      end
      default: begin
        // Plain copy, MOV and LEA
        opnd0_w = opnd1_r;
      end
    endcase
  end

endmodule

//--- meta_unit.sv
`timescale 1ns/1ps

module meta_unit (
  input  x86_isa_pkg::opcode_t opc,
  input  logic [31:0]          opnd_in,
  input  logic [6:0]           status_in,
  output logic                 ah_wr,
  output logic [31:0]          result,
  output logic [6:0]           status_out
);

  import x86_isa_pkg::*;
  import exec_ctl_pkg::*;

  always_comb begin
    ah_wr      = 1'b0;
    result     = opnd_in;
    status_out = status_in;
    case (opc)
      STC: status_out[STAT_CF] = 1'b1;
      CLC: status_out[STAT_CF] = 1'b0;
      STD: status_out[STAT_DF] = 1'b1;
      CLD: status_out[STAT_DF] = 1'b0;
      LAHF: begin
        ah_wr        = 1'b1;
        // AH layout, SF ZF 0 AF 0 PF 1 CF
        result[15:8] = {status_in[STAT_SF], status_in[STAT_ZF], 1'b0,
                        status_in[STAT_AF], 1'b0, status_in[STAT_PF],
                        1'b1, status_in[STAT_CF]};
      end
      SAHF: begin
        // Same AH layout read back, fixed bits ignored
        status_out[STAT_SF] = opnd_in[15];
        status_out[STAT_ZF] = opnd_in[14];
        status_out[STAT_AF] = opnd_in[12];
        status_out[STAT_PF] = opnd_in[10];
        status_out[STAT_CF] = opnd_in[8];
      end
      default: begin
        // Not a meta opcode, status passes through
        status_out = status_in;
      end
    endcase
  end

endmodule

//--- cfu.sv
`timescale 1ns/1ps

module cfu (
  input  x86_isa_pkg::opcode_t opc,
  input  logic [31:0]          eflags,
  input  logic [31:0]          eip,
  input  logic [3:0]           instr_len,
  input  logic [31:0]          address,
  output logic [31:0]          next_eip
);

  import x86_isa_pkg::*;

  logic [31:0] seq_eip;
  logic [31:0] rel_eip;
  logic        zf;

  // Fall-through address
  assign seq_eip = eip + {28'd0, instr_len};
  // Relative targets count from the end of the instruction
  assign rel_eip = seq_eip + address;
  assign zf      = eflags[EFLAGS_ZF];

  always_comb begin
    case (opc)
      // Absolute targets
      JMP, CALLR: begin
        next_eip = address;
      end
      CALLI: begin
        next_eip = rel_eip;
      end
      // Conditional branches on ZF
      JZ: begin
        next_eip = zf ? rel_eip : seq_eip;
      end
      JNZ: begin
        next_eip = zf ? seq_eip : rel_eip;
      end
      default: begin
        // Everything else steps over itself
        next_eip = seq_eip;
      end
    endcase
  end

endmodule

//--- execute.sv
`timescale 1ns/1ps

module execute (
  input  x86_isa_pkg::opcode_t opc,
  input  logic [31:0]          eflags,
  input  logic [31:0]          eip,
  input  logic [3:0]           instr_len,
  input  logic [31:0]          opnd0_r,
  input  logic [31:0]          opnd1_r,
  input  logic [31:0]          opnd2_r,
  output logic [31:0]          o_eflags,
  output logic [31:0]          next_eip,
  output logic [31:0]          opnd0_w,
  output logic [31:0]          opnd1_w
);

  import x86_isa_pkg::*;
  import exec_ctl_pkg::*;

  // Unit selects, at most one is high
  logic        exe_is_alu;
  logic        exe_is_mu;
  logic        exe_is_meta;
  // ALU controls
  alu_op_t     alu_op;
  logic        alu_use_carry;
  logic        alu_no_flags;
  logic        alu_keep_cf;
  logic        alu_no_wr;
  logic        alu_is_call;
  logic        alu_inc_dec;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic [6:0]  alu_status_out;
  // Move unit
  logic [1:0]  mu_kind;
  logic [31:0] mu_opnd0_w;
  logic [31:0] mu_opnd1_w;
  // Meta unit
  logic        ah_wr;
  logic [31:0] meta_result;
  logic [6:0]  meta_status_out;
  // Flags in compact form
  logic [6:0]  status;
  logic [6:0]  unit_status;

  assign exe_is_alu  = opc inside {ADD, ADC, INC, SUB, SBB, DEC, CMP, AND, TEST, OR, XOR,
                                   NOT, SHL, SHR, ROL, ROR, CALLR, CALLI};
  assign exe_is_mu   = opc inside {MOV, LEA, MOVSX, MOVZX, XCHG};
  assign exe_is_meta = opc inside {STC, CLC, STD, CLD, LAHF, SAHF};

  always_comb begin
    case (opc)
      SUB, SBB, DEC, CMP, CALLR, CALLI: alu_op = ALU_SUB;
      AND, TEST:                        alu_op = ALU_AND;
      OR:                               alu_op = ALU_OR;
      XOR, NOT:                         alu_op = ALU_XOR;
      SHL:                              alu_op = ALU_SHL;
      SHR:                              alu_op = ALU_SHR;
      ROL:                              alu_op = ALU_ROL;
      ROR:                              alu_op = ALU_ROR;
      default:                          alu_op = ALU_ADD;
    endcase
  end

  assign alu_use_carry = opc inside {ADC, SBB};
  assign alu_inc_dec   = opc inside {INC, DEC};
  // INC and DEC leave CF alone
  assign alu_keep_cf   = alu_inc_dec;
  // Compares only set flags
  assign alu_no_wr     = opc inside {CMP, TEST};
  assign alu_is_call   = opc inside {CALLR, CALLI};
  // NOT and the stack adjust of a CALL leave EFLAGS as is
  assign alu_no_flags  = (opc == NOT) || alu_is_call;

  // CALL lowers the stack pointer, opnd1 minus opnd2
  assign alu_a = alu_is_call ? opnd1_r : opnd0_r;
  assign alu_b = alu_is_call   ? opnd2_r      :
                 alu_inc_dec   ? 32'd1        :
                 (opc == NOT)  ? 32'hffff_ffff :
                                 opnd1_r;

  assign mu_kind = (opc == MOVSX) ? MV_SEXT :
                   (opc == MOVZX) ? MV_ZEXT :
                   (opc == XCHG)  ? MV_SWAP :
                                    MV_COPY;

  // Pack the unit-visible flags out of EFLAGS
  assign status = {eflags[EFLAGS_DF], eflags[EFLAGS_AF], eflags[EFLAGS_CF],
                   eflags[EFLAGS_PF], eflags[EFLAGS_ZF], eflags[EFLAGS_SF],
                   eflags[EFLAGS_OF]};

  alu u_alu (
    .op         (alu_op),
    .use_carry  (alu_use_carry),
    .no_flags   (alu_no_flags),
    .status_in  (status),
    .a          (alu_a),
    .b          (alu_b),
    .result     (alu_result),
    .status_out (alu_status_out)
  );

  move_unit u_move (
    .kind    (mu_kind),
    .opnd0_r (opnd0_r),
    .opnd1_r (opnd1_r),
    .opnd0_w (mu_opnd0_w),
    .opnd1_w (mu_opnd1_w)
  );

  meta_unit u_meta (
    .opc        (opc),
    .opnd_in    (opnd0_r),
    .status_in  (status),
    .ah_wr      (ah_wr),
    .result     (meta_result),
    .status_out (meta_status_out)
  );

  // Runs on every opcode, the EIP always moves
  cfu u_cfu (
    .opc       (opc),
    .eflags    (eflags),
    .eip       (eip),
    .instr_len (instr_len),
    .address   (opnd0_r),
    .next_eip  (next_eip)
  );

  // Unpack the active unit's status back into EFLAGS
  // IF, TF and reserved bits come straight from the input
  always_comb begin
    unit_status = exe_is_meta ? meta_status_out : alu_status_out;
    if (alu_keep_cf) begin
      unit_status[STAT_CF] = status[STAT_CF];
    end
    o_eflags = eflags;
    if (exe_is_alu || exe_is_meta) begin
      o_eflags[EFLAGS_CF] = unit_status[STAT_CF];
      o_eflags[EFLAGS_PF] = unit_status[STAT_PF];
      o_eflags[EFLAGS_AF] = unit_status[STAT_AF];
      o_eflags[EFLAGS_ZF] = unit_status[STAT_ZF];
      o_eflags[EFLAGS_SF] = unit_status[STAT_SF];
      o_eflags[EFLAGS_DF] = unit_status[STAT_DF];
      o_eflags[EFLAGS_OF] = unit_status[STAT_OF];
    end
  end

  assign opnd0_w = (exe_is_alu && !alu_no_wr) ? alu_result  :
                   exe_is_mu                  ? mu_opnd0_w  :
                   ah_wr                      ? meta_result :
                                                opnd0_r;
  // Stack pointer writeback of a CALL goes out on opnd1
  assign opnd1_w = exe_is_mu   ? mu_opnd1_w :
                   alu_is_call ? alu_result :
                                 opnd1_r;

endmodule

//--- exec_stage.sv
`timescale 1ns/1ps

module exec_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 req,
  output logic                 ack,
  input  x86_isa_pkg::opcode_t opc,
  input  logic [31:0]          eflags,
  input  logic [31:0]          eip,
  input  logic [3:0]           instr_len,
  input  logic [31:0]          opnd0_r,
  input  logic [31:0]          opnd1_r,
  input  logic [31:0]          opnd2_r,
  output logic [31:0]          o_eflags,
  output logic [31:0]          next_eip,
  output logic [31:0]          opnd0_w,
  output logic [31:0]          opnd1_w
);

  import x86_isa_pkg::*;

  // IDLE waits for req, EXEC has the inputs captured,
  // HOLD keeps ack up until req drops
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    EXEC = 2'd1,
    HOLD = 2'd2
  } state_t;

  state_t      state;
  logic        capture;
  logic        load_out;
  // Captured operation
  opcode_t     opc_q;
  logic [31:0] eflags_q;
  logic [31:0] eip_q;
  logic [3:0]  instr_len_q;
  logic [31:0] opnd0_q;
  logic [31:0] opnd1_q;
  logic [31:0] opnd2_q;
  // Combinational results of execute
  logic [31:0] x_eflags;
  logic [31:0] x_next_eip;
  logic [31:0] x_opnd0_w;
  logic [31:0] x_opnd1_w;

  assign capture  = (state == IDLE) && req;
  assign load_out = (state == EXEC);

  // Handshake FSM
  // ack comes up on the edge after the capture edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      ack   <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state <= EXEC;
          end
        end
        EXEC: begin
          state <= HOLD;
          ack   <= 1'b1;
        end
        HOLD: begin
          // Back-pressure, no new capture while req is held
          if (!req) begin
            state <= IDLE;
            ack   <= 1'b0;
          end
        end
        default: begin
          state <= IDLE;
          ack   <= 1'b0;
        end
      endcase
    end
  end

  // Inputs sampled once per request
  always_ff @(posedge clk) begin
    if (capture) begin
      opc_q       <= opc;
      eflags_q    <= eflags;
      eip_q       <= eip;
      instr_len_q <= instr_len;
      opnd0_q     <= opnd0_r;
      opnd1_q     <= opnd1_r;
      opnd2_q     <= opnd2_r;
    end
  end

  execute u_execute (
    .opc       (opc_q),
    .eflags    (eflags_q),
    .eip       (eip_q),
    .instr_len (instr_len_q),
    .opnd0_r   (opnd0_q),
    .opnd1_r   (opnd1_q),
    .opnd2_r   (opnd2_q),
    .o_eflags  (x_eflags),
    .next_eip  (x_next_eip),
    .opnd0_w   (x_opnd0_w),
    .opnd1_w   (x_opnd1_w)
  );

  // Results stay held until the next request completes
  always_ff @(posedge clk) begin
    if (load_out) begin
      o_eflags <= x_eflags;
      next_eip <= x_next_eip;
      opnd0_w  <= x_opnd0_w;
      opnd1_w  <= x_opnd1_w;
    end
  end

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  // Free-running 4 ns clock, starts low
  initial begin
    clk = 1'b0;
    forever begin
      #2 clk = ~clk;
    end
  end

endmodule

//--- exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

  import x86_isa_pkg::*;

  localparam int REPS        = 6;
  localparam int RST_CYCLES  = 5;
  // Ops issued by the stimulus below, each takes at most 8 cycles
  localparam int N_OPS       = 35 * REPS + 4;
  localparam int WATCHDOG_NS = N_OPS * 8 * 4 * 2 + RST_CYCLES * 4;

  logic        clk;
  logic        rst_n;
  logic        req;
  logic        ack;
  opcode_t     opc;
  logic [31:0] eflags;
  logic [31:0] eip;
  logic [3:0]  instr_len;
  logic [31:0] opnd0_r;
  logic [31:0] opnd1_r;
  logic [31:0] opnd2_r;
  logic [31:0] o_eflags;
  logic [31:0] next_eip;
  logic [31:0] opnd0_w;
  logic [31:0] opnd1_w;

  // Expected results of the op in flight
  opcode_t     cur_op;
  logic [31:0] exp_eflags;
  logic [31:0] exp_next_eip;
  logic [31:0] exp_w0;
  logic [31:0] exp_w1;
  int          errors;
  int          n_ops;
  int          n_checked;

  opcode_t arith_ops [0:6] = '{ADD, ADC, INC, SUB, SBB, DEC, CMP};
  opcode_t logic_ops [0:8] = '{AND, OR, XOR, TEST, NOT, SHL, SHR, ROL, ROR};
  opcode_t move_ops  [0:4] = '{MOV, LEA, MOVSX, MOVZX, XCHG};
  opcode_t flag_ops  [0:3] = '{STC, CLC, STD, CLD};

  tb_clock_gen u_clk (
    .clk (clk)
  );

  exec_stage DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .opc       (opc),
    .eflags    (eflags),
    .eip       (eip),
    .instr_len (instr_len),
    .opnd0_r   (opnd0_r),
    .opnd1_r   (opnd1_r),
    .opnd2_r   (opnd2_r),
    .o_eflags  (o_eflags),
    .next_eip  (next_eip),
    .opnd0_w   (opnd0_w),
    .opnd1_w   (opnd1_w)
  );

  // Expected outputs straight from the instruction rules
  function automatic void exec_ref(input opcode_t op, input logic [31:0] fl,
                                   input logic [31:0] ip, input logic [3:0] len,
                                   input logic [31:0] a, input logic [31:0] b,
                                   input logic [31:0] c, output logic [31:0] fl_o,
                                   output logic [31:0] nip, output logic [31:0] w0,
                                   output logic [31:0] w1);
    logic [32:0] wide;
    logic [31:0] opb;
    logic [31:0] r;
    logic [31:0] seq;
    logic [4:0]  n;
    logic        cin;
    logic        set_zsp;
    fl_o    = fl;
    w0      = a;
    w1      = b;
    r       = a;
    n       = b[4:0];
    set_zsp = 1'b0;
    seq     = ip + len;
    case (op)
      ADD, ADC, INC: begin
        opb  = (op == INC) ? 32'd1 : b;
        cin  = (op == ADC) ? fl[EFLAGS_CF] : 1'b0;
        wide = {1'b0, a} + {1'b0, opb} + cin;
        r    = wide[31:0];
        w0   = r;
        // INC keeps the carry
        if (op != INC) fl_o[EFLAGS_CF] = wide[32];
        fl_o[EFLAGS_OF] = (a[31] == opb[31]) && (r[31] != a[31]);
        fl_o[EFLAGS_AF] = ({1'b0, a[3:0]} + {1'b0, opb[3:0]} + cin) > 5'd15;
        set_zsp = 1'b1;
      end
      SUB, SBB, DEC, CMP: begin
        opb  = (op == DEC) ? 32'd1 : b;
        cin  = (op == SBB) ? fl[EFLAGS_CF] : 1'b0;
        wide = {1'b0, a} - {1'b0, opb} - cin;
        r    = wide[31:0];
        if (op != CMP) w0 = r;
        // Top bit of the wide difference is the borrow
        if (op != DEC) fl_o[EFLAGS_CF] = wide[32];
        fl_o[EFLAGS_OF] = (a[31] != opb[31]) && (r[31] != a[31]);
        fl_o[EFLAGS_AF] = {1'b0, a[3:0]} < ({1'b0, opb[3:0]} + cin);
        set_zsp = 1'b1;
      end
      AND, TEST, OR, XOR: begin
        r = (op == OR) ? (a | b) : (op == XOR) ? (a ^ b) : (a & b);
        if (op != TEST) w0 = r;
        fl_o[EFLAGS_CF] = 1'b0;
        fl_o[EFLAGS_OF] = 1'b0;
        fl_o[EFLAGS_AF] = 1'b0;
        set_zsp = 1'b1;
      end
      NOT: w0 = ~a;
      SHL, SHR: begin
        r  = (op == SHL) ? (a << n) : (a >> n);
        w0 = r;
        fl_o[EFLAGS_OF] = 1'b0;
        if (n != 5'd0) fl_o[EFLAGS_CF] = (op == SHL) ? a[32 - n] : a[n - 1];
        set_zsp = 1'b1;
      end
      ROL, ROR: begin
        r  = (op == ROL) ? ((a << n) | (a >> (32 - n))) : ((a >> n) | (a << (32 - n)));
        w0 = r;
        // Only CF moves, and only for a nonzero count
        if (n != 5'd0) fl_o[EFLAGS_CF] = (op == ROL) ? r[0] : r[31];
      end
      MOV, LEA: w0 = b;
      MOVSX:    w0 = {{24{b[7]}}, b[7:0]};
      MOVZX:    w0 = {24'd0, b[7:0]};
      XCHG: begin
        w0 = b;
        w1 = a;
      end
      STC: fl_o[EFLAGS_CF] = 1'b1;
      CLC: fl_o[EFLAGS_CF] = 1'b0;
      STD: fl_o[EFLAGS_DF] = 1'b1;
      CLD: fl_o[EFLAGS_DF] = 1'b0;
      LAHF: w0[15:8] = {fl[EFLAGS_SF], fl[EFLAGS_ZF], 1'b0, fl[EFLAGS_AF], 1'b0,
                        fl[EFLAGS_PF], 1'b1, fl[EFLAGS_CF]};
      SAHF: begin
        fl_o[EFLAGS_SF] = a[15];
        fl_o[EFLAGS_ZF] = a[14];
        fl_o[EFLAGS_AF] = a[12];
        fl_o[EFLAGS_PF] = a[10];
        fl_o[EFLAGS_CF] = a[8];
      end
      // Stack pointer lowered by opnd2, written on both ports
      CALLR, CALLI: begin
        w0 = b - c;
        w1 = b - c;
      end
      default: ;
    endcase
    if (set_zsp) begin
      fl_o[EFLAGS_ZF] = (r == 32'd0);
      fl_o[EFLAGS_SF] = r[31];
      fl_o[EFLAGS_PF] = ~^r[7:0];
    end
    case (op)
      JMP, CALLR: nip = a;
      CALLI:      nip = seq + a;
      JZ:         nip = fl[EFLAGS_ZF] ? seq + a : seq;
      JNZ:        nip = fl[EFLAGS_ZF] ? seq : seq + a;
      default:    nip = seq;
    endcase
  endfunction

  // One op through the four-phase handshake, with timing checks
  task automatic run_op(input opcode_t op, input logic [31:0] fl, input logic [31:0] ip,
                        input logic [3:0] len, input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] c);
    int          cycles;
    int          extra;
    logic [31:0] s_fl;
    logic [31:0] s_ip;
    logic [31:0] s_w0;
    logic [31:0] s_w1;
    cur_op = op;
    exec_ref(op, fl, ip, len, a, b, c, exp_eflags, exp_next_eip, exp_w0, exp_w1);
    @(posedge clk);
    #1;
    opc       = op;
    eflags    = fl;
    eip       = ip;
    instr_len = len;
    opnd0_r   = a;
    opnd1_r   = b;
    opnd2_r   = c;
    req       = 1'b1;
    cycles    = 0;
    while (!ack && cycles < 8) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (ack !== 1'b1) begin
      errors++;
      $display("ERROR at %0t: ack never rose for %s", $time, op.name());
    end else if (cycles != 2) begin
      errors++;
      $display("FAILED %0t: ack rose %0d cycles after req, expected 2", $time, cycles);
    end
    s_fl = o_eflags;
    s_ip = next_eip;
    s_w0 = opnd0_w;
    s_w1 = opnd1_w;
    // Back-pressure, inputs wander while req stays high
    extra = $urandom_range(0, 3);
    repeat (extra) begin
      opc     = opcode_t'(7'($urandom));
      eflags  = $urandom;
      eip     = $urandom;
      opnd0_r = $urandom;
      opnd1_r = $urandom;
      opnd2_r = $urandom;
      @(posedge clk);
      #1;
      if (ack !== 1'b1 || o_eflags !== s_fl || next_eip !== s_ip ||
          opnd0_w !== s_w0 || opnd1_w !== s_w1) begin
        errors++;
        $display("FAILED %0t: ack or outputs moved while req held for %s",
                 $time, op.name());
      end
    end
    req = 1'b0;
    @(posedge clk);
    #1;
    if (ack !== 1'b0) begin
      errors++;
      $display("FAILED %0t: ack still high one cycle after req fell", $time);
    end
    if (o_eflags !== s_fl || next_eip !== s_ip || opnd0_w !== s_w0 || opnd1_w !== s_w1) begin
      errors++;
      $display("FAILED %0t: outputs not held after ack fell", $time);
    end
    n_ops++;
  endtask

  // Compare process, one check per rising ack
  always @(posedge ack) begin
    #1;
    n_checked++;
    if (o_eflags !== exp_eflags) begin
      errors++;
      $display("FAILED %0t: %s eflags %h expected %h", $time, cur_op.name(),
               o_eflags, exp_eflags);
    end
    if (next_eip !== exp_next_eip) begin
      errors++;
      $display("FAILED %0t: %s next_eip %h expected %h", $time, cur_op.name(),
               next_eip, exp_next_eip);
    end
    if (opnd0_w !== exp_w0) begin
      errors++;
      $display("FAILED %0t: %s opnd0_w %h expected %h", $time, cur_op.name(),
               opnd0_w, exp_w0);
    end
    if (opnd1_w !== exp_w1) begin
      errors++;
      $display("FAILED %0t: %s opnd1_w %h expected %h", $time, cur_op.name(),
               opnd1_w, exp_w1);
    end
  end

  // Watchdog sized from the op count
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR: watchdog expired after %0d ns, the handshake hung", WATCHDOG_NS);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int unsigned seed;
    logic [31:0] fl_a;
    logic [31:0] ah_val;
    logic [31:0] sh_b;
    seed      = $urandom(32'hec0d);
    errors    = 0;
    n_ops     = 0;
    n_checked = 0;
    rst_n     = 1'b0;
    req       = 1'b0;
    opc       = NOP;
    eflags    = 32'd0;
    eip       = 32'd0;
    instr_len = 4'd0;
    opnd0_r   = 32'd0;
    opnd1_r   = 32'd0;
    opnd2_r   = 32'd0;
    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (ack !== 1'b0) begin
      errors++;
      $display("ERROR at %0t: ack is not low after reset", $time);
    end

    // Arithmetic, random plus overflow and wrap corners
    foreach (arith_ops[i]) begin
      repeat (REPS) begin
        run_op(arith_ops[i], $urandom, $urandom, 4'($urandom_range(1, 15)),
               $urandom, $urandom, $urandom);
      end
    end
    run_op(ADD, 32'h0, 32'h1000, 4'd2, 32'h7fff_ffff, 32'h1, 32'h0);
    run_op(SUB, 32'h0, 32'h1000, 4'd2, 32'h8000_0000, 32'h1, 32'h0);
    run_op(SBB, 32'h1, 32'h1000, 4'd2, 32'h0, 32'h0, 32'h0);
    run_op(INC, 32'h0, 32'h1000, 4'd2, 32'hffff_ffff, 32'h0, 32'h0);

    // Logic, shift and rotate
    // Count is zero on the first pass and about a quarter of the time after
    foreach (logic_ops[i]) begin
      for (int r = 0; r < REPS; r++) begin
        sh_b = $urandom;
        if (r == 0 || $urandom_range(0, 3) == 0) sh_b[4:0] = 5'd0;
        run_op(logic_ops[i], $urandom, $urandom, 4'($urandom_range(1, 15)),
               $urandom, sh_b, $urandom);
      end
    end

    // Moves
    foreach (move_ops[i]) begin
      repeat (REPS) begin
        run_op(move_ops[i], $urandom, $urandom, 4'($urandom_range(1, 15)),
               $urandom, $urandom, $urandom);
      end
    end

    // Flag set and clear
    foreach (flag_ops[i]) begin
      repeat (REPS) begin
        run_op(flag_ops[i], $urandom, $urandom, 4'($urandom_range(1, 15)),
               $urandom, $urandom, $urandom);
      end
    end

    // LAHF then SAHF over scrambled flags restores them
    repeat (REPS) begin
      fl_a = $urandom;
      run_op(LAHF, fl_a, $urandom, 4'd1, $urandom, $urandom, $urandom);
      ah_val = opnd0_w;
      run_op(SAHF, fl_a ^ 32'h0000_00d5, $urandom, 4'd1, ah_val, $urandom, $urandom);
      if ((o_eflags & 32'h0000_00d5) !== (fl_a & 32'h0000_00d5)) begin
        errors++;
        $display("FAILED %0t: LAHF/SAHF round trip gave %h from %h", $time,
                 o_eflags, fl_a);
      end
    end

    // Control flow, ZF forced both ways for the branches
    repeat (REPS) begin
      run_op(NOP, $urandom, $urandom, 4'($urandom_range(1, 15)), $urandom, $urandom, $urandom);
      run_op(JMP, $urandom, $urandom, 4'($urandom_range(1, 15)), $urandom, $urandom, $urandom);
      run_op(JZ, $urandom | 32'h40, $urandom, 4'($urandom_range(1, 15)),
             $urandom, $urandom, $urandom);
      run_op(JZ, $urandom & ~32'h40, $urandom, 4'($urandom_range(1, 15)),
             $urandom, $urandom, $urandom);
      run_op(JNZ, $urandom | 32'h40, $urandom, 4'($urandom_range(1, 15)),
             $urandom, $urandom, $urandom);
      run_op(JNZ, $urandom & ~32'h40, $urandom, 4'($urandom_range(1, 15)),
             $urandom, $urandom, $urandom);
      run_op(CALLR, $urandom, $urandom, 4'($urandom_range(1, 15)),
             $urandom, $urandom, 32'd4);
      run_op(CALLI, $urandom, $urandom, 4'($urandom_range(1, 15)),
             $urandom, $urandom, 32'd4);
    end

    @(posedge clk);
    #1;
    if (n_checked != n_ops) begin
      errors++;
      $display("ERROR: compare process saw %0d acks for %0d ops", n_checked, n_ops);
    end
    $display("Done: %0d ops, %0d compares, %0d errors", n_ops, n_checked, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- flist.f
x86_isa_pkg.sv
exec_ctl_pkg.sv
alu.sv
move_unit.sv
meta_unit.sv
cfu.sv
execute.sv
exec_stage.sv
tb_clock_gen.sv
exec_tb.sv

//--- Bender.yml
package:
  name: exec_stage

sources:
  - files:
      - x86_isa_pkg.sv
      - exec_ctl_pkg.sv
      - alu.sv
      - move_unit.sv
      - meta_unit.sv
      - cfu.sv
      - execute.sv
      - exec_stage.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - exec_tb.sv
